//--- include/mips_cfg.svh
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// First fetch address
`define MIPS_RESET_PC 32'hbfc0_0000

// Data side segment remap
`define MIPS_KSEG_HI 16'hbfaf
`define MIPS_PHYS_HI 16'h1faf

`define MAIN_CTRL_W 8
`define ALU_CTRL_W 5
`define HAZ_DATA_W 41  // rs/rt D and E, write regs E/M/W, enables, branch
`define HAZ_CTRL_W 12

`endif

//--- verilog/mips_pkg.sv
package mips_pkg;

    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_BEQ   = 6'h04,
        OP_ADDIU = 6'h09,
        OP_LUI   = 6'h0f,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2a
    } funct_e;

    typedef enum logic [4:0] {
        ALU_ADD = 5'd0,
        ALU_SUB = 5'd1,
        ALU_AND = 5'd2,
        ALU_OR  = 5'd3,
        ALU_SLT = 5'd4,
        ALU_LUI = 5'd5
    } alu_op_e;

    // Bit positions in main_control
    localparam int CB_REG_WRITE  = 0;
    localparam int CB_REG_DST    = 1;
    localparam int CB_ALU_SRC    = 2;
    localparam int CB_MEM_EN     = 3;
    localparam int CB_MEM_WRITE  = 4;
    localparam int CB_MEM_TO_REG = 5;
    localparam int CB_BRANCH     = 6;
    localparam int CB_ZERO_EXT   = 7;

    // Bit positions in hazard_control
    localparam int CH_STALL_F = 0;
    localparam int CH_STALL_D = 1;
    localparam int CH_FLUSH_E = 2;
    localparam int CH_STALL_E = 3;
    localparam int CH_STALL_M = 4;
    localparam int CH_STALL_W = 5;
    localparam int CH_FWD_AD  = 6;
    localparam int CH_FWD_BD  = 7;
    localparam int CH_FWD_AE  = 8;   // Two bits wide
    localparam int CH_FWD_BE  = 10;  // Two bits wide

endpackage

//--- verilog/regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic        clk,
    input  logic        arst_n,
    input  logic [4:0]  ra1,
    input  logic [4:0]  ra2,
    input  logic        we,
    input  logic [4:0]  wa,
    input  logic [31:0] wd,
    output logic [31:0] rd1,
    output logic [31:0] rd2
);
    logic [31:0] regs [1:31];  // $0 has no storage

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != 5'd0) begin
            regs[wa] <= wd;
        end
    end

    // Same-cycle write goes straight to the readers
    always_comb begin
        rd1 = '0;
        rd2 = '0;
        if (ra1 != 5'd0) begin
            rd1 = (we && wa == ra1) ? wd : regs[ra1];
        end
        if (ra2 != 5'd0) begin
            rd2 = (we && wa == ra2) ? wd : regs[ra2];
        end
    end
endmodule

//--- verilog/alu.sv
`timescale 1ns/1ps
`include "mips_cfg.svh"

module alu import mips_pkg::*; (
    input  logic [31:0]             a,
    input  logic [31:0]             b,
    input  logic [`ALU_CTRL_W-1:0]  alu_op,
    output logic [31:0]             y
);
    logic [31:0] sum;
    logic [31:0] diff;

    // No overflow trap, unsigned forms only
    assign sum  = a + b;
    assign diff = a - b;

    always_comb begin
        case (alu_op)
            ALU_ADD: y = sum;
            ALU_SUB: y = diff;
            ALU_AND: y = a & b;
            ALU_OR:  y = a | b;
            ALU_SLT: y = {31'd0, $signed(a) < $signed(b)};
            ALU_LUI: y = {b[15:0], 16'd0};  // Immediate into upper half
            default: y = '0;
        endcase
    end
endmodule

//--- verilog/controller.sv
`timescale 1ns/1ps
`include "mips_cfg.svh"

module controller import mips_pkg::*; (
    input  logic [31:0]             instr,
    output logic [`MAIN_CTRL_W-1:0] main_control,
    output logic [`ALU_CTRL_W-1:0]  alu_control
);
    opcode_e opcode;
    funct_e  funct;

    assign opcode = opcode_e'(instr[31:26]);
    assign funct  = funct_e'(instr[5:0]);

    always_comb begin
        main_control = '0;
        alu_control  = ALU_ADD;
        case (opcode)
            OP_RTYPE: begin
                main_control[CB_REG_WRITE] = 1'b1;
                main_control[CB_REG_DST]   = 1'b1;
                case (funct)
                    FN_ADDU: alu_control = ALU_ADD;
                    FN_SUBU: alu_control = ALU_SUB;
                    FN_AND:  alu_control = ALU_AND;
                    FN_OR:   alu_control = ALU_OR;
                    FN_SLT:  alu_control = ALU_SLT;
                    default: main_control = '0;  // Also covers the all-zero nop
                endcase
            end
            OP_ADDIU: begin
                main_control[CB_REG_WRITE] = 1'b1;
                main_control[CB_ALU_SRC]   = 1'b1;
            end
            OP_LUI: begin
                main_control[CB_REG_WRITE] = 1'b1;
                main_control[CB_ALU_SRC]   = 1'b1;
                main_control[CB_ZERO_EXT]  = 1'b1;
                alu_control = ALU_LUI;
            end
            OP_LW: begin
                main_control[CB_REG_WRITE]  = 1'b1;
                main_control[CB_ALU_SRC]    = 1'b1;
                main_control[CB_MEM_EN]     = 1'b1;
                main_control[CB_MEM_TO_REG] = 1'b1;
            end
            OP_SW: begin
                main_control[CB_ALU_SRC]   = 1'b1;
                main_control[CB_MEM_EN]    = 1'b1;
                main_control[CB_MEM_WRITE] = 1'b1;
            end
            OP_BEQ: begin
                main_control[CB_BRANCH] = 1'b1;  // Compare happens in decode
                alu_control = ALU_SUB;
            end
            default: ;
        endcase
    end
endmodule

//--- verilog/hazard.sv
`timescale 1ns/1ps
`include "mips_cfg.svh"

module hazard import mips_pkg::*; (
    input  logic [`HAZ_DATA_W-1:0] hazard_data,
    input  logic                   stall_by_sram,
    output logic [`HAZ_CTRL_W-1:0] hazard_control
);
    logic [4:0] rs_d, rt_d, rs_e, rt_e, write_reg_e, write_reg_m, write_reg_w;
    logic reg_write_e, reg_write_m, reg_write_w, mem_to_reg_e, mem_to_reg_m, branch_d;
    logic lw_stall, br_stall, hold_fd;
    logic [1:0] fwd_ae, fwd_be;

    assign {rs_d, rt_d, rs_e, rt_e, write_reg_e, write_reg_m, write_reg_w,
            reg_write_e, reg_write_m, reg_write_w,
            mem_to_reg_e, mem_to_reg_m, branch_d} = hazard_data;

    // M wins over W
    assign fwd_ae = (reg_write_m && write_reg_m != 5'd0 && write_reg_m == rs_e) ? 2'b10 :
                    (reg_write_w && write_reg_w != 5'd0 && write_reg_w == rs_e) ? 2'b01 : 2'b00;
    assign fwd_be = (reg_write_m && write_reg_m != 5'd0 && write_reg_m == rt_e) ? 2'b10 :
                    (reg_write_w && write_reg_w != 5'd0 && write_reg_w == rt_e) ? 2'b01 : 2'b00;

    assign lw_stall = mem_to_reg_e && (write_reg_e == rs_d || write_reg_e == rt_d);
    assign br_stall = branch_d &&
                      ((reg_write_e && (write_reg_e == rs_d || write_reg_e == rt_d)) ||
                       (mem_to_reg_m && (write_reg_m == rs_d || write_reg_m == rt_d)));
    assign hold_fd  = lw_stall | br_stall;

    always_comb begin
        hazard_control = '0;
        hazard_control[CH_STALL_F] = stall_by_sram | hold_fd;
        hazard_control[CH_STALL_D] = stall_by_sram | hold_fd;
        hazard_control[CH_FLUSH_E] = hold_fd & ~stall_by_sram;  // Freeze keeps E intact
        hazard_control[CH_STALL_E] = stall_by_sram;
        hazard_control[CH_STALL_M] = stall_by_sram;
        hazard_control[CH_STALL_W] = stall_by_sram;
        hazard_control[CH_FWD_AD]  = reg_write_m && write_reg_m != 5'd0 && write_reg_m == rs_d;
        hazard_control[CH_FWD_BD]  = reg_write_m && write_reg_m != 5'd0 && write_reg_m == rt_d;
        hazard_control[CH_FWD_AE +: 2] = fwd_ae;
        hazard_control[CH_FWD_BE +: 2] = fwd_be;
    end
endmodule

//--- verilog/datapath.sv
`timescale 1ns/1ps
`include "mips_cfg.svh"

module datapath import mips_pkg::*; (
    input  logic                    clk,
    input  logic                    arst_n,
    output logic [31:0]             instrD,
    input  logic [`MAIN_CTRL_W-1:0] main_control,
    input  logic [`ALU_CTRL_W-1:0]  alu_control,
    output logic [`HAZ_DATA_W-1:0]  hazard_data,
    input  logic [`HAZ_CTRL_W-1:0]  hazard_control,
    output logic [31:0]             pc,
    output logic                    instr_en,
    input  logic [31:0]             instr,
    output logic [31:0]             mem_addr,
    output logic [31:0]             write_data,
    output logic                    mem_en,
    output logic [3:0]              mem_write_en,
    input  logic [31:0]             read_data,
    output logic [31:0]             pc_w,
    output logic                    reg_write_en_w,
    output logic [4:0]              write_reg_w,
    output logic [31:0]             reg_write_data_w
);
    logic stall_f, stall_d, flush_e, stall_e, stall_m, stall_w;
    logic fwd_ad, fwd_bd;
    logic [1:0] fwd_ae, fwd_be;

    logic [31:0] pc_f, pc_next, pc_plus4_f;
    logic fetch_ok, fresh, hold_valid;
    logic [31:0] hold_instr;

    logic [31:0] pc_d, rd1_d, rd2_d, cmp_a_d, cmp_b_d, imm_d, branch_target_d;
    logic [4:0] rs_d, rt_d, rd_d;
    logic branch_taken_d;

    logic [`MAIN_CTRL_W-1:0] ctrl_e;
    logic [`ALU_CTRL_W-1:0] alu_ctrl_e;
    logic [31:0] pc_e, rd1_e, rd2_e, imm_e, src_a_e, src_b_e, write_data_e, alu_out_e;
    logic [4:0] rs_e, rt_e, rd_e, write_reg_e;

    logic [`MAIN_CTRL_W-1:0] ctrl_m;
    logic [31:0] pc_m, alu_out_m, write_data_m;
    logic [4:0] write_reg_m;

    logic [`MAIN_CTRL_W-1:0] ctrl_w;
    logic [31:0] alu_out_w, result_w, load_hold, load_data_w;
    logic data_fresh;

    assign stall_f = hazard_control[CH_STALL_F];
    assign stall_d = hazard_control[CH_STALL_D];
    assign flush_e = hazard_control[CH_FLUSH_E];
    assign stall_e = hazard_control[CH_STALL_E];
    assign stall_m = hazard_control[CH_STALL_M];
    assign stall_w = hazard_control[CH_STALL_W];
    assign fwd_ad  = hazard_control[CH_FWD_AD];
    assign fwd_bd  = hazard_control[CH_FWD_BD];
    assign fwd_ae  = hazard_control[CH_FWD_AE +: 2];
    assign fwd_be  = hazard_control[CH_FWD_BE +: 2];

    // Fetch, the SRAM answers one cycle after the request
    assign pc_plus4_f = pc_f + 32'd4;
    assign pc_next    = branch_taken_d ? branch_target_d : pc_plus4_f;
    assign pc         = pc_f;
    assign instr_en   = fetch_ok & ~stall_f;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc_f       <= `MIPS_RESET_PC;
            fetch_ok   <= 1'b0;
            fresh      <= 1'b0;
            hold_valid <= 1'b0;
        end else begin
            fetch_ok <= 1'b1;
            fresh    <= instr_en;
            if (instr_en) begin
                pc_f <= pc_next;
            end
            if (!stall_d) begin
                hold_valid <= 1'b0;
            end else if (fresh) begin
                hold_valid <= 1'b1;   // Word is gone after this cycle
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fresh && stall_d) begin
            hold_instr <= instr;
        end
    end

    // Decode, empty slot reads as a bubble
    assign instrD = fresh ? instr : (hold_valid ? hold_instr : 32'd0);

    always_ff @(posedge clk) begin
        if (!stall_d) begin
            pc_d <= pc_f;
        end
    end

    assign rs_d  = instrD[25:21];
    assign rt_d  = instrD[20:16];
    assign rd_d  = instrD[15:11];
    assign imm_d = main_control[CB_ZERO_EXT] ? {16'd0, instrD[15:0]}
                                             : {{16{instrD[15]}}, instrD[15:0]};

    regfile regfile0 (
        .clk    (clk),
        .arst_n (arst_n),
        .ra1    (rs_d),
        .ra2    (rt_d),
        .we     (reg_write_en_w),
        .wa     (write_reg_w),
        .wd     (result_w),
        .rd1    (rd1_d),
        .rd2    (rd2_d)
    );

    // BEQ resolved here, delay slot is already in fetch
    assign cmp_a_d         = fwd_ad ? alu_out_m : rd1_d;
    assign cmp_b_d         = fwd_bd ? alu_out_m : rd2_d;
    assign branch_target_d = pc_d + 32'd4 + {imm_d[29:0], 2'b00};
    assign branch_taken_d  = main_control[CB_BRANCH] && (cmp_a_d == cmp_b_d);

    // Execute
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ctrl_e <= '0;
        end else if (!stall_e) begin
            ctrl_e <= flush_e ? '0 : main_control;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_e) begin
            alu_ctrl_e <= alu_control;
            pc_e       <= pc_d;
            rd1_e      <= rd1_d;
            rd2_e      <= rd2_d;
            imm_e      <= imm_d;
            rs_e       <= rs_d;
            rt_e       <= rt_d;
            rd_e       <= rd_d;
        end
    end

    always_comb begin
        case (fwd_ae)
            2'b10:   src_a_e = alu_out_m;
            2'b01:   src_a_e = result_w;
            default: src_a_e = rd1_e;
        endcase
        case (fwd_be)
            2'b10:   write_data_e = alu_out_m;
            2'b01:   write_data_e = result_w;
            default: write_data_e = rd2_e;
        endcase
    end

    assign src_b_e     = ctrl_e[CB_ALU_SRC] ? imm_e : write_data_e;
    assign write_reg_e = ctrl_e[CB_REG_DST] ? rd_e : rt_e;

    alu alu0 (
        .a      (src_a_e),
        .b      (src_b_e),
        .alu_op (alu_ctrl_e),
        .y      (alu_out_e)
    );

    // Memory
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ctrl_m <= '0;
        end else if (!stall_m) begin
            ctrl_m <= ctrl_e;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_m) begin
            pc_m         <= pc_e;
            alu_out_m    <= alu_out_e;
            write_data_m <= write_data_e;
            write_reg_m  <= write_reg_e;
        end
    end

    assign mem_addr     = alu_out_m;
    assign write_data   = write_data_m;
    assign mem_en       = ctrl_m[CB_MEM_EN] & ~stall_m;
    assign mem_write_en = {4{ctrl_m[CB_MEM_WRITE] & ~stall_m}};

    // Writeback
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ctrl_w     <= '0;
            data_fresh <= 1'b0;
        end else begin
            data_fresh <= mem_en;
            if (!stall_w) begin
                ctrl_w <= ctrl_m;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (data_fresh) begin
            load_hold <= read_data;   // Keeps load data across a freeze
        end
        if (!stall_w) begin
            pc_w        <= pc_m;
            alu_out_w   <= alu_out_m;
            write_reg_w <= write_reg_m;
        end
    end

    assign load_data_w      = data_fresh ? read_data : load_hold;
    assign result_w         = ctrl_w[CB_MEM_TO_REG] ? load_data_w : alu_out_w;
    assign reg_write_en_w   = ctrl_w[CB_REG_WRITE] & ~stall_w;
    assign reg_write_data_w = (write_reg_w == 5'd0) ? 32'd0 : result_w;  // $0 stays zero

    assign hazard_data = {rs_d, rt_d, rs_e, rt_e,
                          write_reg_e, write_reg_m, write_reg_w,
                          ctrl_e[CB_REG_WRITE], ctrl_m[CB_REG_WRITE], ctrl_w[CB_REG_WRITE],
                          ctrl_e[CB_MEM_TO_REG], ctrl_m[CB_MEM_TO_REG],
                          main_control[CB_BRANCH]};
endmodule

//--- verilog/mips.sv
`timescale 1ns/1ps
`include "mips_cfg.svh"

module mips (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        stall_by_sram,

    output logic        inst_sram_en,
    output logic [3:0]  inst_sram_wen,
    output logic [31:0] inst_sram_addr,
    output logic [31:0] inst_sram_wdata,
    input  logic [31:0] inst_sram_rdata,

    output logic        data_sram_en,
    output logic [3:0]  data_sram_wen,
    output logic [31:0] data_sram_addr,
    output logic [31:0] data_sram_wdata,
    input  logic [31:0] data_sram_rdata,

    output logic [31:0] debug_wb_pc,
    output logic [3:0]  debug_wb_rf_wen,
    output logic [4:0]  debug_wb_rf_wnum,
    output logic [31:0] debug_wb_rf_wdata
);
    logic                    reg_write_en_w;
    logic [31:0]             data_addr;
    logic [31:0]             instrD;
    logic [`MAIN_CTRL_W-1:0] main_control;
    logic [`ALU_CTRL_W-1:0]  alu_control;
    logic [`HAZ_DATA_W-1:0]  hazard_data;
    logic [`HAZ_CTRL_W-1:0]  hazard_control;

    // Instruction side is read only
    assign inst_sram_wen   = 4'b0;
    assign inst_sram_wdata = 32'b0;

    assign data_sram_addr = (data_addr[31:16] == `MIPS_KSEG_HI) ?
                            {`MIPS_PHYS_HI, data_addr[15:0]} : data_addr;
    assign debug_wb_rf_wen = {4{reg_write_en_w}};

    datapath datapath0 (
        .clk              (clk),
        .arst_n           (arst_n),
        .instrD           (instrD),
        .main_control     (main_control),
        .alu_control      (alu_control),
        .hazard_data      (hazard_data),
        .hazard_control   (hazard_control),
        .pc               (inst_sram_addr),
        .instr_en         (inst_sram_en),
        .instr            (inst_sram_rdata),
        .mem_addr         (data_addr),
        .write_data       (data_sram_wdata),
        .mem_en           (data_sram_en),
        .mem_write_en     (data_sram_wen),
        .read_data        (data_sram_rdata),
        .pc_w             (debug_wb_pc),
        .reg_write_en_w   (reg_write_en_w),
        .write_reg_w      (debug_wb_rf_wnum),
        .reg_write_data_w (debug_wb_rf_wdata)
    );

    controller controller0 (
        .instr        (instrD),
        .main_control (main_control),
        .alu_control  (alu_control)
    );

    hazard hazard0 (
        .hazard_data    (hazard_data),
        .stall_by_sram  (stall_by_sram),
        .hazard_control (hazard_control)
    );
endmodule

//--- verif/tb_sram.sv
`timescale 1ns/1ps

module tb_sram #(
    parameter int word_bits = 10  // Word address width
) (
    input  logic        clk,
    input  logic        en,
    input  logic [3:0]  wen,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    output logic [31:0] rdata
);
    logic [31:0] mem [0:(1 << word_bits)-1];
    logic [word_bits-1:0] idx;

    assign idx = addr[word_bits+1:2];

    // Background differs for every word
    initial begin
        rdata = '0;
        for (int i = 0; i < (1 << word_bits); i++) begin
            mem[i] = 32'h5a5a_0000 ^ (i << 2) ^ (i << 18);
        end
    end

    // Read data one cycle after the request
    always @(posedge clk) begin
        if (en) begin
            rdata <= mem[idx];
            for (int b = 0; b < 4; b++) begin
                if (wen[b]) begin
                    mem[idx][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end
endmodule

//--- verif/tb_mips.sv
`timescale 1ns/1ps
`include "mips_cfg.svh"

module tb_mips;
    localparam int clk_period   = 20;
    localparam int reset_cycles = 8;
    localparam int num_tests    = 6;

    localparam int op_rtype = 'h00;
    localparam int op_beq   = 'h04;
    localparam int op_addiu = 'h09;
    localparam int op_lui   = 'h0f;
    localparam int op_lw    = 'h23;
    localparam int op_sw    = 'h2b;
    localparam int fn_addu  = 'h21;
    localparam int fn_subu  = 'h23;
    localparam int fn_and   = 'h24;
    localparam int fn_or    = 'h25;
    localparam int fn_slt   = 'h2a;

    logic        clk = 1'b0;
    logic        arst_n;
    logic        stall_by_sram;
    logic        inst_sram_en;
    logic        data_sram_en;
    logic [3:0]  inst_sram_wen;
    logic [3:0]  data_sram_wen;
    logic [3:0]  debug_wb_rf_wen;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_wdata;
    logic [31:0] inst_sram_rdata;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic [31:0] data_sram_rdata;
    logic [31:0] debug_wb_pc;
    logic [31:0] debug_wb_rf_wdata;
    logic [4:0]  debug_wb_rf_wnum;

    logic [31:0] lfsr;
    logic [31:0] prog [$];
    logic [31:0] exp_pc [$];
    logic [4:0]  exp_num [$];
    logic [31:0] exp_val [$];
    logic [31:0] exp_maddr [$];
    logic [3:0]  exp_mwen [$];
    logic [31:0] exp_mwdata [$];
    int          marker_word [num_tests];  // Last program word of each test
    int          marker_idx [num_tests];   // Its position in the retirement stream
    int          errs [num_tests];
    int          cur_test;
    int          ret_idx;
    int          mem_idx;
    int          stall_cycles;
    int          prog_len;
    bit          first_fetch_seen;

    mips dut0 (
        .clk               (clk),
        .arst_n            (arst_n),
        .stall_by_sram     (stall_by_sram),
        .inst_sram_en      (inst_sram_en),
        .inst_sram_wen     (inst_sram_wen),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_wdata   (inst_sram_wdata),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_en      (data_sram_en),
        .data_sram_wen     (data_sram_wen),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    tb_sram imem0 (
        .clk   (clk),
        .en    (inst_sram_en),
        .wen   (inst_sram_wen),
        .addr  (inst_sram_addr),
        .wdata (inst_sram_wdata),
        .rdata (inst_sram_rdata)
    );

    tb_sram dmem0 (
        .clk   (clk),
        .en    (data_sram_en),
        .wen   (data_sram_wen),
        .addr  (data_sram_addr),
        .wdata (data_sram_wdata),
        .rdata (data_sram_rdata)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32+x^22+x^2+x+1
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] enc_r(input int rs, input int rt, input int rd, input int fn);
        return {6'h00, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn[5:0]};
    endfunction

    function automatic logic [31:0] enc_i(input int op, input int rs, input int rt, input int imm);
        return {op[5:0], rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    function automatic string test_name(input int t);
        case (t)
            0:       return "reset";
            1:       return "alu";
            2:       return "memory";
            3:       return "branch";
            4:       return "zero_reg";
            default: return "sram_stall";
        endcase
    endfunction

    // BEQ, delay slot, skipped word, target
    task automatic add_branch(input int rs, input int rt, input int base);
        prog.push_back(enc_i(op_beq, rs, rt, 2));
        prog.push_back(enc_i(op_addiu, 0, base, 'h0100 + base));
        prog.push_back(enc_i(op_addiu, 0, base + 1, 'h0200 + base));
        prog.push_back(enc_i(op_addiu, 0, base + 2, 'h0300 + base));
    endtask

    task automatic build_program();
        logic [31:0] r;
        for (int i = 1; i <= 6; i++) begin
            r = rand_bits(32);
            prog.push_back(enc_i(op_lui, 0, i, r[31:16]));
            prog.push_back(enc_i(op_addiu, i, i, r[15:0]));  // Needs the LUI just before
        end
        prog.push_back(enc_r(1, 2, 26, fn_addu));
        prog.push_back(enc_r(26, 3, 27, fn_subu));  // From M
        prog.push_back(enc_r(26, 4, 28, fn_and));   // From W
        prog.push_back(enc_r(27, 28, 29, fn_or));
        prog.push_back(enc_r(1, 2, 30, fn_slt));
        prog.push_back(enc_r(2, 1, 31, fn_slt));
        prog.push_back(enc_i(op_addiu, 26, 26, 'hedcc));
        marker_word[1] = prog.size() - 1;
        prog.push_back(enc_i(op_lui, 0, 7, `MIPS_KSEG_HI));
        prog.push_back(enc_i(op_addiu, 7, 7, 'h0100));
        prog.push_back(enc_i(op_sw, 7, 3, 'h0004));
        prog.push_back(enc_i(op_sw, 7, 4, 'h0008));
        prog.push_back(enc_i(op_lw, 7, 8, 'h0004));
        prog.push_back(enc_r(8, 2, 9, fn_addu));   // Load-use
        prog.push_back(enc_i(op_lw, 7, 10, 'h0008));
        marker_word[2] = prog.size() - 1;
        add_branch(1, 1, 11);
        add_branch(1, 2, 14);
        prog.push_back(enc_r(1, 0, 17, fn_addu));
        add_branch(17, 1, 18);                     // Operand still in E
        prog.push_back(enc_i(op_lw, 7, 21, 'h0004));
        add_branch(21, 3, 22);                     // Operand from a load
        marker_word[3] = prog.size() - 1;
        prog.push_back(enc_i(op_addiu, 1, 0, 'h0005));
        prog.push_back(enc_r(1, 2, 0, fn_or));
        prog.push_back(enc_r(0, 2, 25, fn_addu));
        prog.push_back(enc_r(0, 0, 12, fn_or));
        marker_word[4] = prog.size() - 1;
        // Self loop parks the core
        prog.push_back(enc_i(op_beq, 0, 0, 'hffff));
        prog.push_back(32'h0);
    endtask

    // Program data lives in the 0xbfaf segment
    task automatic add_access(input logic [31:0] addr, input logic [3:0] wen,
                              input logic [31:0] wdata);
        exp_maddr.push_back({`MIPS_PHYS_HI, addr[15:0]});
        exp_mwen.push_back(wen);
        exp_mwdata.push_back(wdata);
    endtask

    // In-order ISA model with one delay slot
    task automatic run_model();
        logic [31:0] regs [32];
        logic [31:0] dmem [1024];
        logic [31:0] pc, npc, tgt, ins, a, b, imm, val, ea;
        int wr;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        pc  = `MIPS_RESET_PC;
        npc = pc + 4;
        while (pc != `MIPS_RESET_PC + 4 * (prog_len - 2)) begin
            ins = prog[(pc - `MIPS_RESET_PC) >> 2];
            a   = regs[ins[25:21]];
            b   = regs[ins[20:16]];
            imm = {{16{ins[15]}}, ins[15:0]};
            ea  = a + imm;
            tgt = npc + 4;
            wr  = -1;
            val = '0;
            case (ins[31:26])
                op_rtype: begin
                    wr = ins[15:11];
                    case (ins[5:0])
                        fn_addu: val = a + b;
                        fn_subu: val = a - b;
                        fn_and:  val = a & b;
                        fn_or:   val = a | b;
                        fn_slt:  val = {31'd0, $signed(a) < $signed(b)};
                        default: wr = -1;
                    endcase
                end
                op_addiu: begin
                    wr  = ins[20:16];
                    val = a + imm;
                end
                op_lui: begin
                    wr  = ins[20:16];
                    val = {ins[15:0], 16'h0000};
                end
                op_lw: begin
                    wr  = ins[20:16];
                    val = dmem[ea >> 2 & 32'h3ff];
                    add_access(ea, 4'h0, 32'h0);
                end
                op_sw: begin
                    dmem[ea >> 2 & 32'h3ff] = b;
                    add_access(ea, 4'hf, b);
                end
                op_beq:  tgt = (a == b) ? npc + (imm << 2) : tgt;
                default: ;
            endcase
            if (wr >= 0) begin
                val = (wr == 0) ? 32'd0 : val;
                regs[wr] = val;
                exp_pc.push_back(pc);
                exp_num.push_back(wr[4:0]);
                exp_val.push_back(val);
                for (int t = 1; t <= 4; t++) begin
                    if ((pc - `MIPS_RESET_PC) >> 2 == marker_word[t]) begin
                        marker_idx[t] = exp_pc.size() - 1;
                    end
                end
            end
            pc  = npc;
            npc = tgt;
        end
    endtask

    task automatic mismatch(input int t, input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        $display("MISMATCH at %0t ns: %s = %h, expected %h", $time, name, got, exp);
        errs[t]++;
    endtask

    task automatic note_error(input int t, input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        errs[t]++;
    endtask

    task automatic report_test(input int t);
        $display("[%0d] %s: %s, %0d errors", t, test_name(t), (errs[t] == 0) ? "ok" : "bad",
                 errs[t]);
    endtask

    task automatic check_retire();
        assert (!stall_by_sram)
            else note_error(5, "an instruction retired while stall_by_sram was high");
        if (ret_idx >= exp_pc.size()) begin
            note_error(5, $sformatf("extra retirement of pc %h", debug_wb_pc));
        end else begin
            assert (debug_wb_rf_wen == 4'hf)
                else mismatch(cur_test, "debug_wb_rf_wen", debug_wb_rf_wen, 32'hf);
            assert (debug_wb_pc == exp_pc[ret_idx])
                else mismatch(cur_test, "debug_wb_pc", debug_wb_pc, exp_pc[ret_idx]);
            assert (debug_wb_rf_wnum == exp_num[ret_idx])
                else mismatch(cur_test, "debug_wb_rf_wnum", debug_wb_rf_wnum, exp_num[ret_idx]);
            assert (debug_wb_rf_wdata == exp_val[ret_idx])
                else mismatch(cur_test, "debug_wb_rf_wdata", debug_wb_rf_wdata, exp_val[ret_idx]);
            if (cur_test <= 4 && ret_idx == marker_idx[cur_test]) begin
                report_test(cur_test);
                cur_test++;
            end
            ret_idx++;
        end
    endtask

    task automatic check_mem_access();
        if (mem_idx >= exp_maddr.size()) begin
            note_error(cur_test, $sformatf("extra data SRAM access to %h", data_sram_addr));
        end else begin
            assert (data_sram_addr == exp_maddr[mem_idx])
                else mismatch(cur_test, "data_sram_addr", data_sram_addr, exp_maddr[mem_idx]);
            assert (data_sram_wen == exp_mwen[mem_idx])
                else mismatch(cur_test, "data_sram_wen", data_sram_wen, exp_mwen[mem_idx]);
            if (exp_mwen[mem_idx] != 4'h0) begin
                assert (data_sram_wdata == exp_mwdata[mem_idx])
                    else mismatch(cur_test, "data_sram_wdata", data_sram_wdata,
                                  exp_mwdata[mem_idx]);
            end
            mem_idx++;
        end
    endtask

    task automatic finish_run();
        int bad;
        int total;
        bad   = 0;
        total = 0;
        for (int t = 0; t < num_tests; t++) begin
            total += errs[t];
            bad   += (errs[t] != 0);
        end
        $display("summary: %0d tests, %0d bad, %0d/%0d retired, %0d stall cycles, %0d errors",
                 num_tests, bad, ret_idx, exp_pc.size(), stall_cycles, total);
        if (total == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    endtask

    initial begin
        forever #(clk_period / 2) clk = ~clk;
    end

    // Outputs are settled by the falling edge
    always @(negedge clk) begin
        if (!arst_n) begin
            assert (!inst_sram_en && !data_sram_en && debug_wb_rf_wen == 4'b0)
                else note_error(0, "SRAM or writeback enable active during reset");
        end else begin
            stall_cycles += stall_by_sram;
            assert (inst_sram_wen == 4'b0)
                else mismatch(cur_test, "inst_sram_wen", inst_sram_wen, 32'h0);
            assert (inst_sram_wdata == 32'b0)
                else mismatch(cur_test, "inst_sram_wdata", inst_sram_wdata, 32'h0);
            if (inst_sram_en && !first_fetch_seen) begin
                first_fetch_seen = 1'b1;
                assert (inst_sram_addr == `MIPS_RESET_PC)
                    else mismatch(0, "inst_sram_addr", inst_sram_addr, `MIPS_RESET_PC);
                report_test(0);
            end
            if (data_sram_en) begin
                check_mem_access();
            end
            if (debug_wb_rf_wen != 4'b0) begin
                check_retire();
            end
        end
    end

    // Random freezes about one cycle in four
    initial begin
        stall_by_sram = 1'b0;
        wait (arst_n === 1'b1);
        forever begin
            @(posedge clk);
            #2;
            stall_by_sram = (rand_bits(2) == 0);
        end
    end

    initial begin
        arst_n           = 1'b0;
        lfsr             = 32'h2625_5172;
        cur_test         = 1;
        ret_idx          = 0;
        mem_idx          = 0;
        stall_cycles     = 0;
        first_fetch_seen = 1'b0;
        for (int t = 0; t < num_tests; t++) begin
            errs[t]        = 0;
            marker_word[t] = -1;
            marker_idx[t]  = -1;
        end
        build_program();
        prog_len = prog.size();
        run_model();
        #1;
        for (int i = 0; i < prog_len; i++) begin
            imem0.mem[i] = prog[i];  // After the SRAM background fill
        end
        repeat (reset_cycles) @(posedge clk);
        #2;
        arst_n = 1'b1;
        wait (ret_idx == exp_pc.size());
        repeat (20) @(posedge clk);  // Window for a stray retirement
        assert (mem_idx == exp_maddr.size())
            else note_error(5, "a data SRAM access never reached the SRAM");
        report_test(5);
        finish_run();
    end

    initial begin
        wait (prog_len > 0);
        #(clk_period * (reset_cycles + 8 * prog_len));
        $display("ERROR: watchdog expired after %0d of %0d retirements", ret_idx, exp_pc.size());
        $display("test failed");
        $finish;
    end
endmodule

//--- project.f
+incdir+include
verilog/mips_pkg.sv
verilog/regfile.sv
verilog/alu.sv
verilog/controller.sv
verilog/hazard.sv
verilog/datapath.sv
verilog/mips.sv
verif/tb_sram.sv
verif/tb_mips.sv
